// File: calc_pkg.sv
/*
 * Shared definitions for the calculator core: memory map, timing,
 * opcode constants, ALU and mode codes, FSM states, opcode union
 */

`default_nettype none

package calc_pkg;

    // --------------------------------------------------
    // Memory map and widths
    // --------------------------------------------------
    localparam int MEM_AW = 14;     // 16 KB program/data memory
    localparam int ADDR_W = 16;     // CPU address bus
    localparam int DATA_W = 8;

    localparam logic [ADDR_W-1:0] IO_OUT_ADDR = 16'hC000; // Result port, also I/O base
    localparam logic [ADDR_W-1:0] IO_KEY_ADDR = 16'hC001; // Keys in bits 1:0

    // --------------------------------------------------
    // Timing of the step enable
    // --------------------------------------------------
    localparam int LOCK_CYCLES = 16;    // Stand-in for the PLL lock time
    localparam int STEP_DIV    = 4;     // 100 MHz / 4 = 25 MHz step
    localparam int LOCK_W      = $clog2(LOCK_CYCLES + 1);
    localparam int DIV_W       = $clog2(STEP_DIV);

    // Single-byte opcodes
    localparam logic [7:0] OP_BRK = 8'h00;
    localparam logic [7:0] OP_CLC = 8'h18;
    localparam logic [7:0] OP_SEC = 8'h38;
    localparam logic [7:0] OP_JMP = 8'h4C;  // JMP abs
    localparam logic [7:0] OP_BNE = 8'hD0;
    localparam logic [7:0] OP_BEQ = 8'hF0;
    localparam logic [7:0] OP_NOP = 8'hEA;

    // Group-one aaa field
    localparam logic [2:0] ALU_ORA = 3'b000;
    localparam logic [2:0] ALU_AND = 3'b001;
    localparam logic [2:0] ALU_EOR = 3'b010;
    localparam logic [2:0] ALU_ADC = 3'b011;
    localparam logic [2:0] ALU_STA = 3'b100;
    localparam logic [2:0] ALU_LDA = 3'b101;
    localparam logic [2:0] ALU_SBC = 3'b111;  // 110 (CMP) not supported

    // Group-one bbb field
    localparam logic [2:0] MODE_IMM = 3'b010;
    localparam logic [2:0] MODE_ABS = 3'b011;

    // CPU FSM states
    localparam logic [2:0] ST_FETCH      = 3'd0;
    localparam logic [2:0] ST_OPERAND_LO = 3'd1;
    localparam logic [2:0] ST_OPERAND_HI = 3'd2;
    localparam logic [2:0] ST_MEM        = 3'd3;
    localparam logic [2:0] ST_HALT       = 3'd4;

    // One opcode byte, matched whole or split into 6502 fields
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] aaa;    // Operation
            logic [2:0] bbb;    // Addressing mode
            logic [1:0] cc;     // Group, 01 = group one
        } f;
    } opcode_u;

endpackage

`default_nettype wire

// File: cpu_clock_enable.sv
/*
 * Step enable for the CPU: lock delay after reset, then
 * a one-clock pulse every STEP_DIV clocks while running
 */

`timescale 1ns/1ps
`default_nettype none

module cpu_clock_enable
    import calc_pkg::*;
(
    input  wire logic clk,
    input  wire logic i_rst,
    input  wire logic i_run,
    output logic      o_step
);

    logic [LOCK_W-1:0] lock_cnt;
    logic              locked;      // Plays the role of PLL locked
    logic [DIV_W-1:0]  div_cnt;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            lock_cnt <= '0;
            locked   <= 1'b0;
        end else if (!locked) begin
            lock_cnt <= lock_cnt + 1'b1;
            if (lock_cnt == LOCK_W'(LOCK_CYCLES - 1))
                locked <= 1'b1;
        end
    end

    // Divider only runs once locked and enabled
    always_ff @(posedge clk) begin
        if (i_rst || !locked || !i_run)
            div_cnt <= '0;
        else if (div_cnt == DIV_W'(STEP_DIV - 1))
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    assign o_step = locked && i_run && (div_cnt == DIV_W'(STEP_DIV - 1));

    // Step must stay a single-clock pulse
    a_step_pulse: assert property (@(posedge clk) disable iff (i_rst)
        o_step |=> !o_step);

endmodule

`default_nettype wire

// File: prog_mem.sv
/*
 * 16 KB synchronous RAM, registered read on the CPU address,
 * load port for the testbench and step-qualified CPU write
 */

`timescale 1ns/1ps
`default_nettype none

module prog_mem
    import calc_pkg::*;
(
    input  wire logic              clk,

    // Load port, used while the CPU is idle
    input  wire logic              i_load_we,
    input  wire logic [MEM_AW-1:0] i_load_addr,
    input  wire logic [DATA_W-1:0] i_load_data,

    // CPU port
    input  wire logic              i_step,
    input  wire logic              i_cpu_we,     // Write level, already range-checked
    input  wire logic [MEM_AW-1:0] i_cpu_addr,
    input  wire logic [DATA_W-1:0] i_cpu_wdata,
    output logic      [DATA_W-1:0] o_rdata
);

    logic [DATA_W-1:0] mem [0:(1 << MEM_AW) - 1];

    logic cpu_commit;

    // Level alone would write every clock until the next step
    assign cpu_commit = i_step && i_cpu_we;

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_load_we)                      // Loader wins
            mem[i_load_addr] <= i_load_data;
        else if (cpu_commit)
            mem[i_cpu_addr] <= i_cpu_wdata;
    end

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_cpu_addr];         // One clock after address
    end

    // Loader and running CPU must never overlap
    a_no_dual_write: assert property (@(posedge clk)
        !(i_load_we && cpu_commit));

endmodule

`default_nettype wire

// File: io_port.sv
/*
 * I/O block: address decode, result register with valid pulse,
 * LED latch, two-flop key synchronizer and read-mux select
 */

`timescale 1ns/1ps
`default_nettype none

module io_port
    import calc_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              i_rst,
    input  wire logic              i_step,
    input  wire logic [ADDR_W-1:0] i_addr,
    input  wire logic              i_wr,
    input  wire logic [DATA_W-1:0] i_wdata,
    input  wire logic [1:0]        i_keys,
    output logic      [DATA_W-1:0] o_rdata,
    output logic                   o_sel_io,
    output logic      [DATA_W-1:0] o_out_data,
    output logic                   o_out_valid,
    output logic      [3:0]        o_led
);

    logic       is_io;
    logic       out_hit;
    logic [1:0] key_meta;
    logic [1:0] key_sync;

    assign is_io   = (i_addr >= IO_OUT_ADDR);                           // Top 16 KB
    assign out_hit = i_step && i_wr && (i_addr == IO_OUT_ADDR);        // Committed store

    always_ff @(posedge clk) begin
        key_meta <= i_keys;     // Keys are asynchronous
        key_sync <= key_meta;
    end

    // Registered like the RAM so read timing matches
    always_ff @(posedge clk) begin
        o_rdata <= (i_addr == IO_KEY_ADDR) ? {{(DATA_W - 2){1'b0}}, key_sync} : '0;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_sel_io    <= 1'b0;
            o_out_valid <= 1'b0;
            o_led       <= 4'h0;
        end else begin
            o_sel_io    <= is_io;
            o_out_valid <= out_hit;
            if (out_hit)
                o_led <= i_wdata[3:0];      // Low nibble shown on LEDs
        end
    end

    // Result byte held until the next store
    always_ff @(posedge clk) begin
        if (out_hit)
            o_out_data <= i_wdata;
    end

endmodule

`default_nettype wire

// File: cpu_alu.sv
/*
 * Accumulator ALU: ORA, AND, EOR, ADC, SBC and LDA pass-through
 * with zero and carry flags
 */

`timescale 1ns/1ps
`default_nettype none

module cpu_alu
    import calc_pkg::*;
(
    input  wire logic [2:0]        i_op,   // aaa field of the opcode
    input  wire logic [DATA_W-1:0] i_a,    // Accumulator
    input  wire logic [DATA_W-1:0] i_b,    // Operand
    input  wire logic              i_c,    // Carry in
    output logic      [DATA_W-1:0] o_y,
    output logic                   o_z,
    output logic                   o_c
);

    logic [DATA_W:0] sum;

    always_comb begin
        sum = '0;
        o_y = i_a;      // Unknown ops keep A
        o_c = i_c;      // Carry only moves on ADC/SBC

        case (i_op)
            ALU_ORA: o_y = i_a | i_b;
            ALU_AND: o_y = i_a & i_b;
            ALU_EOR: o_y = i_a ^ i_b;
            ALU_LDA: o_y = i_b;
            ALU_ADC: begin
                sum = {1'b0, i_a} + {1'b0, i_b} + {{DATA_W{1'b0}}, i_c};
                o_y = sum[DATA_W-1:0];
                o_c = sum[DATA_W];
            end
            ALU_SBC: begin
                // 6502 style, carry set means no borrow
                sum = {1'b0, i_a} + {1'b0, ~i_b} + {{DATA_W{1'b0}}, i_c};
                o_y = sum[DATA_W-1:0];
                o_c = sum[DATA_W];
            end
            default: ;
        endcase
    end

    assign o_z = (o_y == '0);

endmodule

`default_nettype wire

// File: demo_cpu.sv
/*
 * 6502-subset accumulator CPU: fetch/decode/execute FSM,
 * PC, A and the Z and C flags, stepped by the clock enable
 */

`timescale 1ns/1ps
`default_nettype none

module demo_cpu
    import calc_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              i_rst,
    input  wire logic              i_step,
    input  wire logic [DATA_W-1:0] i_rdata,
    output logic      [ADDR_W-1:0] o_addr,
    output logic      [DATA_W-1:0] o_wdata,
    output logic                   o_wr,     // Write level committed by the step
    output logic                   o_halted
);

    logic [2:0]        state;
    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] ea;          // Effective address for abs mode
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] lo;          // Low operand byte
    logic              z;
    logic              c;

    opcode_u           ir;          // Current instruction
    opcode_u           op_in;       // Byte on the bus during fetch

    logic              branch_taken;
    logic [DATA_W-1:0] alu_y;
    logic              alu_z;
    logic              alu_c;

    // --------------------------------------------------
    // Decode helpers, group one only
    // --------------------------------------------------
    function automatic logic alu_ok(input opcode_u op);
        return op.f.cc == 2'b01 &&
               op.f.aaa inside {ALU_ORA, ALU_AND, ALU_EOR, ALU_ADC,
                                ALU_STA, ALU_LDA, ALU_SBC};
    endfunction

    function automatic logic is_imm(input opcode_u op);
        return alu_ok(op) && op.f.bbb == MODE_IMM && op.f.aaa != ALU_STA;  // No STA #
    endfunction

    function automatic logic is_abs(input opcode_u op);
        return alu_ok(op) && op.f.bbb == MODE_ABS;
    endfunction

    assign op_in = opcode_u'(i_rdata);

    assign branch_taken = (ir.raw == OP_BNE && !z) || (ir.raw == OP_BEQ && z);

    // Operand is always the bus byte in imm or abs mode
    cpu_alu u_alu (
        .i_op (ir.f.aaa),
        .i_a  (a),
        .i_b  (i_rdata),
        .i_c  (c),
        .o_y  (alu_y),
        .o_z  (alu_z),
        .o_c  (alu_c)
    );

    // --------------------------------------------------
    // Main FSM, moves only on step
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= ST_FETCH;
            pc    <= '0;            // No reset vector
            a     <= '0;
            z     <= 1'b0;
            c     <= 1'b0;
        end else if (i_step) begin
            case (state)
                ST_FETCH: begin
                    ir <= op_in;
                    pc <= pc + 1'b1;
                    case (op_in.raw)
                        OP_BRK: state <= ST_HALT;
                        OP_CLC: c <= 1'b0;
                        OP_SEC: c <= 1'b1;
                        OP_JMP, OP_BNE, OP_BEQ: state <= ST_OPERAND_LO;
                        OP_NOP: ;   // One byte, nothing to do
                        default: begin
                            if (is_imm(op_in) || is_abs(op_in))
                                state <= ST_OPERAND_LO;
                        end         // Anything else runs as NOP
                    endcase
                end

                ST_OPERAND_LO: begin
                    pc <= pc + 1'b1;
                    lo <= i_rdata;
                    if (ir.raw == OP_BNE || ir.raw == OP_BEQ) begin
                        if (branch_taken) // Relative to PC after operand
                            pc <= pc + 1'b1 + {{(ADDR_W - DATA_W){i_rdata[7]}}, i_rdata};
                        state <= ST_FETCH;
                    end else if (is_imm(ir)) begin
                        a     <= alu_y;
                        z     <= alu_z;
                        c     <= alu_c;
                        state <= ST_FETCH;
                    end else begin
                        state <= ST_OPERAND_HI;     // JMP or abs
                    end
                end

                ST_OPERAND_HI: begin
                    if (ir.raw == OP_JMP) begin
                        pc    <= {i_rdata, lo};
                        state <= ST_FETCH;
                    end else begin
                        ea    <= {i_rdata, lo};
                        pc    <= pc + 1'b1;
                        state <= ST_MEM;
                    end
                end

                ST_MEM: begin
                    // Store is done by the memory/IO on this step
                    if (ir.f.aaa != ALU_STA) begin
                        a <= alu_y;
                        z <= alu_z;
                        c <= alu_c;
                    end
                    state <= ST_FETCH;
                end

                ST_HALT: ;          // Stays until reset

                default: state <= ST_FETCH;
            endcase
        end
    end

    // Bus outputs come from registers only, stable between steps
    assign o_addr   = (state == ST_MEM) ? ea : pc;
    assign o_wdata  = a;
    assign o_wr     = (state == ST_MEM) && (ir.f.aaa == ALU_STA);
    assign o_halted = (state == ST_HALT);

    // Stores reach the bus only from an absolute-mode MEM cycle
    a_wr_in_mem: assert property (@(posedge clk) disable iff (i_rst)
        o_wr |-> state == ST_MEM && ir.f.cc == 2'b01 && ir.f.bbb == MODE_ABS);

endmodule

`default_nettype wire

// File: calc_soc.sv
/*
 * Calculator core top: step enable, CPU, program memory,
 * I/O block and the read-data mux
 */

`timescale 1ns/1ps
`default_nettype none

module calc_soc
    import calc_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              i_rst,
    input  wire logic              i_run,
    input  wire logic              i_load_we,
    input  wire logic [MEM_AW-1:0] i_load_addr,
    input  wire logic [DATA_W-1:0] i_load_data,
    input  wire logic [1:0]        i_keys,
    output logic      [DATA_W-1:0] o_out_data,
    output logic                   o_out_valid,
    output logic      [3:0]        o_led,
    output logic                   o_halted
);

    logic              step;
    logic [ADDR_W-1:0] cpu_addr;
    logic [DATA_W-1:0] cpu_wdata;
    logic [DATA_W-1:0] cpu_rdata;
    logic              cpu_wr;
    logic              mem_we;
    logic [DATA_W-1:0] mem_rdata;
    logic [DATA_W-1:0] io_rdata;
    logic              sel_io;

    // Replaces the PLL and its 25 MHz output
    cpu_clock_enable u_clk_en (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_run  (i_run),
        .o_step (step)
    );

    demo_cpu u_cpu (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_step   (step),
        .i_rdata  (cpu_rdata),
        .o_addr   (cpu_addr),
        .o_wdata  (cpu_wdata),
        .o_wr     (cpu_wr),
        .o_halted (o_halted)
    );

    assign mem_we = cpu_wr && (cpu_addr < IO_OUT_ADDR);    // RAM range only

    prog_mem u_mem (
        .clk         (clk),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_step      (step),
        .i_cpu_we    (mem_we),
        .i_cpu_addr  (cpu_addr[MEM_AW-1:0]),
        .i_cpu_wdata (cpu_wdata),
        .o_rdata     (mem_rdata)
    );

    io_port u_io (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_step      (step),
        .i_addr      (cpu_addr),
        .i_wr        (cpu_wr),
        .i_wdata     (cpu_wdata),
        .i_keys      (i_keys),
        .o_rdata     (io_rdata),
        .o_sel_io    (sel_io),
        .o_out_data  (o_out_data),
        .o_out_valid (o_out_valid),
        .o_led       (o_led)
    );

    // Select follows the registered read data
    assign cpu_rdata = sel_io ? io_rdata : mem_rdata;

endmodule

`default_nettype wire

// File: tb_cpu_model.svh
/*
 * Reference model of the 6502 subset and the program builders
 * shared by the calculator testbench
 */

`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

localparam int MAX_INSTR = 256;         // Longest program run in any test

logic [DATA_W-1:0] prog [$];            // Program image from address 0
logic [DATA_W-1:0] exp_out [$];         // Predicted result bytes
logic [DATA_W-1:0] model_mem [0:(1 << MEM_AW) - 1];
logic              exp_halt;
logic [1:0]        model_keys;          // Keys as the DUT sees them

// --------------------------------------------------
// Program builders
// --------------------------------------------------
task automatic put_op(input logic [7:0] b);
    prog.push_back(b);
endtask

task automatic put_imm(input logic [2:0] aaa, input logic [7:0] val);
    prog.push_back({aaa, MODE_IMM, 2'b01});     // Group one, immediate
    prog.push_back(val);
endtask

task automatic put_abs(input logic [2:0] aaa, input logic [15:0] addr);
    prog.push_back({aaa, MODE_ABS, 2'b01});     // Group one, absolute
    prog.push_back(addr[7:0]);                  // Little endian
    prog.push_back(addr[15:8]);
endtask

task automatic put_jmp(input int target);
    prog.push_back(OP_JMP);
    prog.push_back(8'(target));
    prog.push_back(8'(target >> 8));
endtask

// Offset counts from the byte after the operand
task automatic put_branch(input logic [7:0] op, input int target);
    prog.push_back(op);
    prog.push_back(8'(target - prog.size() - 1));
endtask

task automatic patch_branch(input int at, input int target);
    prog[at + 1] = 8'(target - (at + 2));
endtask

task automatic patch_jmp(input int at, input int target);
    prog[at + 1] = 8'(target);
    prog[at + 2] = 8'(target >> 8);
endtask

// RAM below the I/O base, keys at their port, zeros elsewhere
function automatic logic [7:0] model_read(input logic [15:0] addr);
    if (addr < IO_OUT_ADDR)
        return model_mem[addr[MEM_AW-1:0]];
    return (addr == IO_KEY_ADDR) ? {6'b000000, model_keys} : 8'h00;
endfunction

// --------------------------------------------------
// Instruction-level model
// --------------------------------------------------
task automatic run_model();
    opcode_u     op;
    logic [15:0] pc;
    logic [15:0] ea;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [8:0]  sum;
    logic        z;
    logic        c;
    logic        grp1;
    logic        taken;
    int          n;

    for (n = 0; n < (1 << MEM_AW); n++)
        model_mem[n] = (n < prog.size()) ? prog[n] : 8'h00;
    exp_out.delete();
    exp_halt = 1'b0;
    pc = '0;
    a  = '0;
    b  = '0;
    z  = 1'b0;
    c  = 1'b0;
    for (n = 0; n < MAX_INSTR && !exp_halt; n++) begin
        op   = opcode_u'(model_read(pc));
        pc   = pc + 16'd1;
        grp1 = (op.f.cc == 2'b01) && (op.f.aaa != 3'b110);     // CMP left out
        if (op.raw == OP_BRK)
            exp_halt = 1'b1;
        else if (op.raw == OP_CLC)
            c = 1'b0;
        else if (op.raw == OP_SEC)
            c = 1'b1;
        else if (op.raw == OP_JMP)
            pc = {model_read(pc + 16'd1), model_read(pc)};
        else if (op.raw == OP_BNE || op.raw == OP_BEQ) begin
            b     = model_read(pc);
            pc    = pc + 16'd1;
            taken = (op.raw == OP_BNE) ? !z : z;
            if (taken)
                pc = pc + {{8{b[7]}}, b};       // Signed offset
        end else if (grp1 && (op.f.bbb == MODE_ABS ||
                              (op.f.bbb == MODE_IMM && op.f.aaa != ALU_STA))) begin
            if (op.f.bbb == MODE_IMM) begin
                b  = model_read(pc);
                pc = pc + 16'd1;
            end else begin
                ea = {model_read(pc + 16'd1), model_read(pc)};
                pc = pc + 16'd2;
                if (op.f.aaa == ALU_STA) begin
                    if (ea == IO_OUT_ADDR)
                        exp_out.push_back(a);       // Result port
                    else if (ea < IO_OUT_ADDR)
                        model_mem[ea[MEM_AW-1:0]] = a;
                end else begin
                    b = model_read(ea);
                end
            end
            if (op.f.aaa != ALU_STA) begin
                case (op.f.aaa)
                    ALU_ORA: a = a | b;
                    ALU_AND: a = a & b;
                    ALU_EOR: a = a ^ b;
                    ALU_LDA: a = b;
                    ALU_ADC: begin
                        sum = {1'b0, a} + {1'b0, b} + {8'h00, c};
                        a   = sum[7:0];
                        c   = sum[8];
                    end
                    ALU_SBC: begin
                        sum = {1'b0, a} + {1'b0, ~b} + {8'h00, c};  // Carry = no borrow
                        a   = sum[7:0];
                        c   = sum[8];
                    end
                    default: ;
                endcase
                z = (a == 8'h00);
            end
        end
        // Any other byte is a one-byte NOP
    end
endtask

`endif

// File: tb_calc_soc.sv
/*
 * Testbench for the calculator core: clock, reset, program loader,
 * random programs checked against the CPU model, watchdog
 */

`timescale 1ns/1ps
`default_nettype none

module tb_calc_soc
    import calc_pkg::*;
();

    logic              clk;
    logic              i_rst;
    logic              i_run;
    logic              i_load_we;
    logic [MEM_AW-1:0] i_load_addr;
    logic [DATA_W-1:0] i_load_data;
    logic [1:0]        i_keys;
    logic [DATA_W-1:0] o_out_data;
    logic              o_out_valid;
    logic [3:0]        o_led;
    logic              o_halted;

    `include "tb_cpu_model.svh"

    localparam int CLK_PERIOD  = 20;
    localparam int MEM_SIZE    = 1 << MEM_AW;
    localparam int N_TESTS     = 6;
    localparam int RUN_LIMIT   = LOCK_CYCLES + MAX_INSTR * 4 * STEP_DIV;  // Clocks per run
    localparam int TEST_CLOCKS = 8 + MEM_SIZE + RUN_LIMIT + 200;         // Load, run, idle tail
    localparam int WATCHDOG_NS = N_TESTS * TEST_CLOCKS * CLK_PERIOD + LOCK_CYCLES * CLK_PERIOD;

    string             test_name;
    int                err_count;
    int                check_count;
    int                test_errs;
    int                tests_run;
    int                tests_ok;
    int                post_halt_pulses;
    logic [DATA_W-1:0] got_out [$];        // Every result seen on the port

    calc_soc DUT (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_run       (i_run),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_keys      (i_keys),
        .o_out_data  (o_out_data),
        .o_out_valid (o_out_valid),
        .o_led       (o_led),
        .o_halted    (o_halted)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Results sampled mid-cycle, away from the edge
    always @(negedge clk) begin
        if (o_out_valid) begin
            got_out.push_back(o_out_data);
            if (o_halted)
                post_halt_pulses++;     // Nothing may follow BRK
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, simulation stopped", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    // --------------------------------------------------
    // Checks and reporting
    // --------------------------------------------------
    task automatic flag_failure(input string msg);
        $display("test %s: %s", test_name, msg);
        err_count++;
        test_errs++;
    endtask

    task automatic check_byte(input string what, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        check_count++;
        if (exp !== act) begin
            $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_nibble(input string what, input logic [3:0] exp, input logic [3:0] act);
        check_count++;
        if (exp !== act) begin
            $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        check_count++;
        if (exp !== act) begin
            $display("ERROR %s: %s expected %b actual %b", test_name, what, exp, act);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
        prog.delete();
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errs == 0) begin
            tests_ok++;
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: FAIL with %0d errors", test_name, test_errs);
        end
    endtask

    // --------------------------------------------------
    // DUT sequencing
    // --------------------------------------------------
    task automatic apply_reset();
        @(posedge clk);
        #1;
        i_rst = 1'b1;
        i_run = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        i_rst = 1'b0;
    endtask

    // One pass over the whole RAM, program bytes first, zeros after
    task automatic load_memory();
        int i;
        for (i = 0; i < MEM_SIZE; i++) begin
            i_load_we   = 1'b1;
            i_load_addr = MEM_AW'(i);
            i_load_data = (i < prog.size()) ? prog[i] : 8'h00;
            @(posedge clk);
            #1;
        end
        i_load_we = 1'b0;
    endtask

    task automatic run_and_check();
        int          clocks;
        int          first;
        int          halt_base;
        int          n_got;
        int          i;
        logic [7:0]  last;

        run_model();
        apply_reset();
        load_memory();
        first     = got_out.size();
        halt_base = post_halt_pulses;
        i_run     = 1'b1;
        clocks    = 0;
        @(negedge clk);
        while (!o_halted && clocks < RUN_LIMIT) begin
            @(negedge clk);
            clocks++;
        end
        if (!o_halted)
            flag_failure($sformatf("CPU did not halt within %0d clocks", RUN_LIMIT));
        repeat (200) @(negedge clk);    // Quiet tail after the halt
        n_got = got_out.size() - first;
        check_bit("halted", exp_halt, o_halted);
        if (n_got != exp_out.size())
            flag_failure($sformatf("expected %0d results but saw %0d", exp_out.size(), n_got));
        for (i = 0; i < n_got && i < exp_out.size(); i++)
            check_byte($sformatf("result %0d", i), exp_out[i], got_out[first + i]);
        last = (exp_out.size() > 0) ? exp_out[$] : 8'h00;
        check_nibble("led", last[3:0], o_led);
        if (post_halt_pulses != halt_base)
            flag_failure("a result was emitted after the CPU halted");
        @(posedge clk);
        #1;
        i_run = 1'b0;
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_reset();
        int k;
        start_test("reset");
        apply_reset();
        for (k = 0; k < 2; k++) begin   // Right after reset, then past the lock time
            @(negedge clk);
            check_bit("out_valid", 1'b0, o_out_valid);
            check_bit("halted", 1'b0, o_halted);
            check_nibble("led", 4'h0, o_led);
            repeat (LOCK_CYCLES + 2 * STEP_DIV) @(negedge clk);
        end
        finish_test();
    endtask

    task automatic test_alu_chain();
        logic [2:0] ops [5];
        int         n;
        int         i;
        start_test("alu_chain");
        ops = '{ALU_ORA, ALU_AND, ALU_EOR, ALU_ADC, ALU_SBC};
        n   = $urandom_range(12, 6);
        put_op(OP_CLC);
        put_imm(ALU_LDA, 8'($urandom()));
        put_abs(ALU_STA, IO_OUT_ADDR);
        for (i = 0; i < n; i++) begin
            if ($urandom_range(2, 0) == 0)
                put_op(($urandom_range(1, 0) == 1) ? OP_SEC : OP_CLC);
            put_imm(ops[$urandom_range(4, 0)], 8'($urandom()));
            put_abs(ALU_STA, IO_OUT_ADDR);      // Every step is a result
        end
        put_op(OP_BRK);
        run_and_check();
        finish_test();
    endtask

    task automatic test_store_load();
        logic [15:0] addr [6];
        int          i;
        start_test("store_load");
        for (i = 0; i < 6; i++) begin
            addr[i] = 16'h1000 + 16'(i * 256) + 16'($urandom_range(255, 0));  // Distinct pages
            put_imm(ALU_LDA, 8'($urandom()));
            put_abs(ALU_STA, addr[i]);
        end
        for (i = 0; i < 6; i++) begin
            put_abs(ALU_LDA, addr[i]);
            put_abs(ALU_STA, IO_OUT_ADDR);
        end
        put_op(OP_BRK);
        run_and_check();
        finish_test();
    endtask

    task automatic test_branch_loop();
        int loop_at;
        int beq_at;
        int jmp_at;
        start_test("branch_loop");
        put_imm(ALU_LDA, 8'($urandom_range(20, 1)));
        loop_at = prog.size();
        put_abs(ALU_STA, IO_OUT_ADDR);
        put_op(OP_SEC);
        put_imm(ALU_SBC, 8'h01);
        put_branch(OP_BNE, loop_at);            // Back while nonzero
        beq_at = prog.size();
        put_branch(OP_BEQ, 0);
        put_imm(ALU_LDA, 8'hEE);                // Skipped by BEQ
        put_abs(ALU_STA, IO_OUT_ADDR);
        patch_branch(beq_at, prog.size());
        jmp_at = prog.size();
        put_jmp(0);
        put_imm(ALU_LDA, 8'hDD);                // Skipped by JMP
        put_abs(ALU_STA, IO_OUT_ADDR);
        patch_jmp(jmp_at, prog.size());
        put_imm(ALU_LDA, 8'($urandom()));
        put_abs(ALU_STA, IO_OUT_ADDR);
        put_op(OP_BRK);
        run_and_check();
        finish_test();
    endtask

    task automatic test_key_read();
        start_test("key_read");
        i_keys     = 2'($urandom_range(3, 1));  // Held nonzero for the whole run
        model_keys = i_keys;
        put_abs(ALU_LDA, IO_KEY_ADDR);
        put_abs(ALU_STA, IO_OUT_ADDR);
        put_op(OP_BRK);
        run_and_check();
        finish_test();
    endtask

    task automatic test_halt();
        start_test("halt");
        put_imm(ALU_LDA, 8'($urandom()));
        put_abs(ALU_STA, IO_OUT_ADDR);
        put_op(OP_BRK);
        put_imm(ALU_LDA, 8'h77);                // Dead code past BRK
        put_abs(ALU_STA, IO_OUT_ADDR);
        put_abs(ALU_STA, IO_OUT_ADDR);
        put_jmp(0);
        run_and_check();
        finish_test();
    endtask

    initial begin
        int seed_init;
        i_rst       = 1'b1;
        i_run       = 1'b0;
        i_load_we   = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        i_keys      = 2'b00;
        model_keys  = 2'b00;
        err_count   = 0;
        check_count = 0;
        tests_run   = 0;
        tests_ok    = 0;
        seed_init   = $urandom(32'h1cb4);
        test_reset();
        test_alu_chain();
        test_store_load();
        test_branch_loop();
        test_key_read();
        test_halt();
        $display("Summary: %0d of %0d tests clean, %0d checks, %0d errors",
                 tests_ok, tests_run, check_count, err_count);
        if (err_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
calc_pkg.sv
cpu_clock_enable.sv
prog_mem.sv
io_port.sv
cpu_alu.sv
demo_cpu.sv
calc_soc.sv
tb_calc_soc.sv

// File: run.sh
#!/bin/sh
# Build the calculator core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_calc_soc -o sim_calc_soc

output=$(./obj_dir/sim_calc_soc)
echo "$output"
echo "$output" | grep -qx "Test passed"
